// File: common/rvCore_params.svh
// ####################
// Core width and reset parameters
// ####################

`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// Data path width
`define XLEN 32

// Byte address width on the memory port
`define ADDR_W 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: common/rvCorePkg.sv
// ####################
// Shared types of the multicycle RV32I core
// FSM states, opcodes, ALU ops and mux selects
// ####################

package rvCorePkg;

    // Controller states, encodings as in the classic multicycle FSM
    typedef enum logic [3:0] {
        sFetch    = 4'd0,
        sDecode   = 4'd1,
        sMemAddr  = 4'd2,
        sMemRead  = 4'd3,
        sMemWb    = 4'd4,
        sMemWrite = 4'd5,
        sExecuteR = 4'd6,
        sAluWb    = 4'd7,
        sExecuteI = 4'd8,
        sJal      = 4'd9,
        sBeq      = 4'd10,
        sError    = 4'd15   // Sticky, core halted
    } ctrlStateT;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,  // R-type ALU
        opImm    = 7'b0010011,  // I-type ALU
        opJal    = 7'b1101111,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101     // Signed compare
    } aluOpT;

    typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARegA} srcASelT;

    typedef enum logic [1:0] {srcBRegB, srcBImm, srcBFour} srcBSelT;

    // Result bus source
    typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSelT;

    typedef enum logic [1:0] {immI, immS, immB, immJ} immSelT;

endpackage

// File: rtl/controller.sv
// ####################
// Multicycle control FSM
// Moore state outputs, memory strobe sequencing and ALU decode
// ####################

`timescale 1ns/100ps

module controller import rvCorePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  opcodeT    opcode,
    input  logic [2:0] funct3,
    input  logic      funct7b5,
    input  logic      zero,       // From ALU, beq taken when set
    input  logic      memBusy,
    input  logic      memAck,
    output logic      memStb,
    output logic      memWe,
    output logic      adrSrc,     // 0 PC, 1 result bus
    output logic      pcWrite,
    output logic      irWrite,
    output logic      regWrite,
    output srcASelT   srcA,
    output srcBSelT   srcB,
    output resultSelT resultSel,
    output immSelT    immSel,
    output aluOpT     aluCtrl,
    output logic      halted
);

    ctrlStateT state, nextState;
    logic issued;    // Request of the current memory state is out
    logic started;   // Low for the reset cycle, keeps the port quiet
    logic memState;  // Fetch, memRead or memWrite

    // ALU op for R and I types
    function automatic aluOpT decodeAlu(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  decodeAlu = sub ? aluSub : aluAdd;
            3'b010:  decodeAlu = aluSlt;
            3'b110:  decodeAlu = aluOr;
            3'b111:  decodeAlu = aluAnd;
            default: decodeAlu = aluAdd;  // Unsupported funct3
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= sFetch;
            issued  <= 1'b0;
            started <= 1'b0;
        end
        else
        begin
            state   <= nextState;
            started <= 1'b1;
            if (memAck)
                issued <= 1'b0;     // Response closes the request
            else if (memStb)
                issued <= 1'b1;
        end
    end

    assign memState = (state == sFetch) || (state == sMemRead) || (state == sMemWrite);
    // One strobe per memory state, first non-busy cycle
    assign memStb = started && memState && !issued && !memBusy;

    // Next state
    always_comb
    begin
        nextState = state;
        case (state)
            sFetch:    if (memAck) nextState = sDecode;
            sDecode:
            begin
                case (opcode)
                    opLoad, opStore: nextState = sMemAddr;
                    opReg:           nextState = sExecuteR;
                    opImm:           nextState = sExecuteI;
                    opJal:           nextState = sJal;
                    opBranch:        nextState = (funct3 == 3'b000) ? sBeq : sError;
                    default:         nextState = sError;  // Illegal opcode
                endcase
            end
            sMemAddr:  nextState = (opcode == opStore) ? sMemWrite : sMemRead;
            sMemRead:  if (memAck) nextState = sMemWb;
            sMemWb:    nextState = sFetch;
            sMemWrite: if (memAck) nextState = sFetch;
            sExecuteR, sExecuteI, sJal: nextState = sAluWb;
            sAluWb:    nextState = sFetch;
            sBeq:      nextState = sFetch;
            default:   nextState = sError;  // Error holds here
        endcase
    end

    // Immediate format follows the opcode
    always_comb
    begin
        case (opcode)
            opStore:  immSel = immS;
            opBranch: immSel = immB;
            opJal:    immSel = immJ;
            default:  immSel = immI;
        endcase
    end

    // Moore outputs, plus ack gating in fetch
    always_comb
    begin
        adrSrc    = 1'b0;
        srcA      = srcARegA;
        srcB      = srcBImm;
        aluCtrl   = aluAdd;
        resultSel = resAluOut;
        pcWrite   = 1'b0;
        irWrite   = 1'b0;
        regWrite  = 1'b0;
        memWe     = 1'b0;
        halted    = 1'b0;
        case (state)
            sFetch:
            begin
                srcA      = srcAPc;        // PC + 4
                srcB      = srcBFour;
                resultSel = resAluResult;
                irWrite   = memAck;
                pcWrite   = memAck;
            end
            sDecode:   srcA = srcAOldPc;   // Branch or jump target into aluOut
            sMemRead:  adrSrc = 1'b1;      // ALU keeps recomputing rs1 + imm
            sMemWb:
            begin
                resultSel = resData;
                regWrite  = 1'b1;
            end
            sMemWrite:
            begin
                adrSrc = 1'b1;
                memWe  = 1'b1;
            end
            sExecuteR:
            begin
                srcB    = srcBRegB;
                aluCtrl = decodeAlu(funct3, funct7b5);
            end
            sExecuteI: aluCtrl = decodeAlu(funct3, 1'b0);
            sAluWb:    regWrite = 1'b1;
            sJal:
            begin
                srcA    = srcAOldPc;       // Link value
                srcB    = srcBFour;
                pcWrite = 1'b1;            // Target from decode
            end
            sBeq:
            begin
                srcB    = srcBRegB;
                aluCtrl = aluSub;
                pcWrite = zero;
            end
            sError:    halted = 1'b1;
            default:   halted = 1'b0;
        endcase
    end

    // Memory port rules
    assert property (@(posedge clk) disable iff (reset) memAck |-> issued)
        else $error("memAck with no request outstanding");
    assert property (@(posedge clk) disable iff (reset) memStb |=> !memStb)
        else $error("memStb with a request outstanding");

endmodule

// File: datapath/rvAlu.sv
// ####################
// Combinational ALU
// add, sub, and, or, signed slt with zero flag
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module rvAlu import rvCorePkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  aluOpT            aluCtrl,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [`XLEN-1:0] diff;
    logic             lessThan;

    // Shared by sub, beq and slt
    assign diff = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (aluCtrl)
            aluAdd:  result = a + b;
            aluSub:  result = diff;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {{(`XLEN-1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

    // Branch compare result
    assign zero = (result == '0);

endmodule

// File: datapath/regFile.sv
// ####################
// 32 x XLEN register file
// Two async reads, one write, x0 reads zero
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       ra1,
    input  logic [4:0]       ra2,
    input  logic [4:0]       wa,
    input  logic [`XLEN-1:0] wd,
    input  logic             we,
    output logic [`XLEN-1:0] rd1,
    output logic [`XLEN-1:0] rd2
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;      // Known start state for the program
        end
        else if (we && (wa != 5'd0))
            regs[wa] <= wd;         // x0 never written
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: datapath/rvDatapath.sv
// ####################
// Multicycle datapath
// PC, IR, data and ALU-out registers, operand muxes, immediates
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module rvDatapath import rvCorePkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              pcWrite,
    input  logic              irWrite,
    input  logic              regWrite,
    input  logic              adrSrc,
    input  srcASelT           srcA,
    input  srcBSelT           srcB,
    input  resultSelT         resultSel,
    input  immSelT            immSel,
    input  aluOpT             aluCtrl,
    input  logic [`XLEN-1:0]  memRdata,
    output logic [`ADDR_W-1:0] memAddr,
    output logic [`XLEN-1:0]  memWdata,
    output opcodeT            opcode,
    output logic [2:0]        funct3,
    output logic              funct7b5,
    output logic              zero
);

    localparam logic [`XLEN-1:0] Four = `XLEN'd4;

    logic [`XLEN-1:0] pc, oldPc, instr, data;
    logic [`XLEN-1:0] regA, regB, aluOut;
    logic [`XLEN-1:0] rd1, rd2, imm;
    logic [`XLEN-1:0] aVal, bVal, aluResult, result;
    logic [`XLEN-1:0] adr;

    // PC takes PC + 4 or a jump target
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pc <= `RESET_PC;
        else if (pcWrite)
            pc <= result;
    end

    always_ff @(posedge clk)
    begin
        if (irWrite)
        begin
            instr <= memRdata;
            oldPc <= pc;            // PC of this instruction
        end
        data   <= memRdata;         // Holds the word taken on memAck
        regA   <= rd1;
        regB   <= rd2;
        aluOut <= aluResult;
    end

    regFile uRegs (
        .clk   (clk),
        .reset (reset),
        .ra1   (instr[19:15]),
        .ra2   (instr[24:20]),
        .wa    (instr[11:7]),
        .wd    (result),
        .we    (regWrite),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    // Sign-extended immediate per format
    always_comb
    begin
        case (immSel)
            immS:    imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            immJ:    imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb
    begin
        case (srcA)
            srcAPc:    aVal = pc;
            srcAOldPc: aVal = oldPc;
            default:   aVal = regA;
        endcase
        case (srcB)
            srcBRegB: bVal = regB;
            srcBImm:  bVal = imm;
            default:  bVal = Four;  // PC increment and link
        endcase
    end

    rvAlu uAlu (
        .a       (aVal),
        .b       (bVal),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    always_comb
    begin
        case (resultSel)
            resData:      result = data;
            resAluResult: result = aluResult;
            default:      result = aluOut;
        endcase
    end

    assign adr      = adrSrc ? result : pc;   // Data access or fetch
    assign memAddr  = adr[`ADDR_W-1:0];
    assign memWdata = regB;                   // rs2 for sw

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

endmodule

// File: rtl/rvCore.sv
// ####################
// RV32I subset multicycle core
// Controller plus datapath on one word memory port
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module rvCore import rvCorePkg::*; (
    input  logic               clk,
    input  logic               reset,
    output logic               memStb,
    output logic               memWe,
    output logic [`ADDR_W-1:0] memAddr,
    output logic [`XLEN-1:0]   memWdata,
    input  logic               memBusy,
    input  logic               memAck,
    input  logic [`XLEN-1:0]   memRdata,
    output logic               halted
);

    // Controller to datapath
    logic      pcWrite, irWrite, regWrite, adrSrc;
    srcASelT   srcA;
    srcBSelT   srcB;
    resultSelT resultSel;
    immSelT    immSel;
    aluOpT     aluCtrl;

    // Datapath status back to the FSM
    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5, zero;

    controller uCtrl (
        .clk (clk), .reset (reset),
        .opcode (opcode), .funct3 (funct3), .funct7b5 (funct7b5), .zero (zero),
        .memBusy (memBusy), .memAck (memAck), .memStb (memStb), .memWe (memWe),
        .adrSrc (adrSrc), .pcWrite (pcWrite), .irWrite (irWrite),
        .regWrite (regWrite), .srcA (srcA), .srcB (srcB),
        .resultSel (resultSel), .immSel (immSel), .aluCtrl (aluCtrl),
        .halted (halted)
    );

    rvDatapath uDp (
        .clk (clk), .reset (reset),
        .pcWrite (pcWrite), .irWrite (irWrite), .regWrite (regWrite),
        .adrSrc (adrSrc), .srcA (srcA), .srcB (srcB),
        .resultSel (resultSel), .immSel (immSel), .aluCtrl (aluCtrl),
        .memRdata (memRdata), .memAddr (memAddr), .memWdata (memWdata),
        .opcode (opcode), .funct3 (funct3), .funct7b5 (funct7b5), .zero (zero)
    );

endmodule

// File: tb/rvCoreChecker.sv
// ####################
// Memory port checker for the core
// Handshake rules, store comparison, halt behavior
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module rvCoreChecker #(
    parameter int NumStores = 13,
    parameter int MemBytes  = 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               memStb,
    input  logic               memWe,
    input  logic [`ADDR_W-1:0] memAddr,
    input  logic [`XLEN-1:0]   memWdata,
    input  logic               memBusy,
    input  logic               memAck,
    input  logic               halted,
    input  logic [63:0]        expStores [NumStores],  // {address, data} in store order
    output int                 errorCount,
    output int                 storeCount,
    output logic               haltSeen
);

    int   errors      = 0;
    int   storeIdx    = 0;      // Next entry of the store table
    logic outstanding = 1'b0;   // Request sent, no ack yet
    logic firstReq    = 1'b1;
    logic halt        = 1'b0;

    assign errorCount = errors;
    assign storeCount = storeIdx;
    assign haltSeen   = halt;

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic reportProblem(input string what);
        $display("at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Next store must match the table entry
    task automatic checkStore();
        if (storeIdx >= NumStores)
            reportProblem($sformatf("unexpected store of %h to %h", memWdata, memAddr));
        else
        begin
            if (memAddr != expStores[storeIdx][63:32])
                reportMismatch("memAddr", memAddr, expStores[storeIdx][63:32]);
            if (memWdata != expStores[storeIdx][31:0])
                reportMismatch("memWdata", memWdata, expStores[storeIdx][31:0]);
            storeIdx++;
        end
    endtask

    task automatic checkRequest();
        if (memBusy)
            reportProblem("memStb raised while memBusy was high");
        if (outstanding)
            reportProblem("new memStb while a request was still outstanding");
        if (halt)
            reportProblem("memStb after the core halted");
        if (memAddr >= 32'(MemBytes))
            reportProblem($sformatf("access to %h outside the memory model", memAddr));
        if (firstReq)
        begin
            firstReq = 1'b0;        // Must be a fetch of the reset PC
            if (memWe)
                reportMismatch("memWe", 32'(memWe), 32'd0);
            if (memAddr != `RESET_PC)
                reportMismatch("memAddr", memAddr, `RESET_PC);
        end
        if (memWe)
            checkStore();
    endtask

    // Mid-cycle sampling, all port signals settled
    always @(negedge clk)
    begin
        if (reset)
        begin
            if (memStb)
                reportMismatch("memStb", 32'(memStb), 32'd0);
            if (memWe)
                reportMismatch("memWe", 32'(memWe), 32'd0);
            if (halted)
                reportMismatch("halted", 32'(halted), 32'd0);
        end
        else
        begin
            if (memStb)
                checkRequest();
            if (memAck && !outstanding)
                reportProblem("memAck with no request outstanding");
            if (memAck)
                outstanding = 1'b0;
            if (memStb)
                outstanding = 1'b1;
            if (halted && !halt)
            begin
                halt = 1'b1;        // Illegal opcode reached
                if (storeIdx != NumStores)
                    reportProblem($sformatf("halted after %0d of %0d expected stores",
                                            storeIdx, NumStores));
            end
        end
    end

endmodule

// File: tb/rvCoreTb.sv
// ####################
// Testbench for the multicycle RV32I core
// Word memory with random latency, program and expected stores
// ####################

`timescale 1ns/100ps

`include "rvCore_params.svh"

module rvCoreTb;

    localparam int ProgWords     = 36;
    localparam int NumStores     = 13;
    localparam int MemWords      = 256;     // 1 KiB, byte address bits 9:2
    localparam int MaxLatency    = 5;       // Ack delay of 4 plus a busy cycle
    localparam int TimeoutCycles = ProgWords * 8 * MaxLatency * 2;
    localparam int QuietCycles   = 20;      // Watch window after halt

    localparam logic [2:0] F3Add = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3Slt = 3'b010;
    localparam logic [2:0] F3Or  = 3'b110;
    localparam logic [2:0] F3And = 3'b111;

    logic               clk;
    logic               reset;
    logic               memStb, memWe, memBusy, memAck, halted;
    logic [`ADDR_W-1:0] memAddr;
    logic [`XLEN-1:0]   memWdata, memRdata;

    logic [31:0] mem [MemWords];
    logic [31:0] progTable [ProgWords];
    logic [63:0] dataTable [2];             // {address, word}
    logic [63:0] expStores [NumStores];     // {address, data}
    logic [31:0] rngState = 32'hf8ba_27fa;

    int   errorCount, storeCount;
    logic haltSeen;
    int   cycles   = 0;
    logic timedOut = 1'b0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Instruction encoders, RV32I formats
    function automatic logic [31:0] aluImm(input logic [2:0] f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] aluReg(input logic sub, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] loadWord(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchEq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jumpLink(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    rvCore u_dut (
        .clk (clk), .reset (reset),
        .memStb (memStb), .memWe (memWe), .memAddr (memAddr), .memWdata (memWdata),
        .memBusy (memBusy), .memAck (memAck), .memRdata (memRdata), .halted (halted)
    );

    rvCoreChecker #(.NumStores (NumStores), .MemBytes (MemWords * 4)) uCheck (
        .clk (clk), .reset (reset),
        .memStb (memStb), .memWe (memWe), .memAddr (memAddr), .memWdata (memWdata),
        .memBusy (memBusy), .memAck (memAck), .halted (halted),
        .expStores (expStores), .errorCount (errorCount), .storeCount (storeCount),
        .haltSeen (haltSeen)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    // Memory model, one request at a time
    initial
    begin
        logic [31:0] reqAddr, reqData, dataAddr;
        logic        reqWrite, reqPending;
        int          ackWait;
        memBusy    = 1'b0;
        memAck     = 1'b0;
        memRdata   = '0;
        reqPending = 1'b0;
        reqWrite   = 1'b0;
        reqAddr    = '0;
        reqData    = '0;
        ackWait    = 0;
        progTable = '{
            aluImm(F3Add, 1, 0, 5),         // 00 x1 = 5
            aluImm(F3Add, 2, 0, -3),        // 04 x2 = -3
            aluReg(1'b0, F3Add, 3, 1, 2),   // 08 x3 = 2
            aluReg(1'b1, F3Add, 4, 2, 1),   // 0c x4 = -8
            storeWord(3, 0, 'h200),
            storeWord(4, 0, 'h204),
            aluReg(1'b0, F3Slt, 5, 2, 1),   // 18 -3 < 5 gives 1
            aluImm(F3Add, 6, 0, 9),
            aluReg(1'b0, F3Slt, 6, 1, 2),   // 20 5 < -3 gives 0, over 9
            aluImm(F3Slt, 7, 2, -2),        // 24 -3 < -2 gives 1
            storeWord(5, 0, 'h208),
            storeWord(6, 0, 'h20c),
            storeWord(7, 0, 'h210),
            aluImm(F3Or, 8, 1, 'h0f0),      // 34 x8 = f5
            aluImm(F3And, 9, 2, 'h0ff),     // 38 x9 = fd
            aluReg(1'b0, F3Or, 10, 4, 1),   // 3c x10 = -3
            aluReg(1'b0, F3And, 11, 8, 9),  // 40 x11 = f5
            aluImm(F3Add, 0, 1, 7),         // 44 x0 stays 0
            storeWord(10, 0, 'h214),
            storeWord(11, 0, 'h218),
            storeWord(0, 0, 'h21c),
            loadWord(12, 0, 'h100),         // 54
            aluImm(F3Add, 13, 0, 'h108),
            loadWord(14, 13, -4),           // 5c from 104
            storeWord(12, 0, 'h220),
            storeWord(14, 13, 'h10),        // 64 to 118
            branchEq(1, 2, 8),              // 68 not taken
            storeWord(1, 0, 'h224),
            branchEq(3, 3, 8),              // 70 taken to 78
            storeWord(2, 0, 'h228),         // Wrong path
            storeWord(3, 0, 'h22c),
            jumpLink(15, 12),               // 7c to 88, link 80
            storeWord(1, 0, 'h230),         // Skipped
            storeWord(1, 0, 'h234),         // Skipped
            storeWord(15, 0, 'h238),
            32'hffff_ffff                   // 8c illegal opcode
        };
        dataTable = '{
            {32'h0000_0100, 32'h1234_5678},
            {32'h0000_0104, 32'hcafe_f00d}
        };
        for (int i = 0; i < MemWords; i++)
            mem[i] = 32'h5a5a_0000 ^ 32'(i * 4);
        for (int i = 0; i < ProgWords; i++)
            mem[i] = progTable[i];
        for (int i = 0; i < 2; i++)
        begin
            dataAddr = dataTable[i][63:32];
            mem[dataAddr[9:2]] = dataTable[i][31:0];
        end
        forever
        begin
            @(negedge clk);
            if (memStb)
            begin
                reqAddr    = memAddr;
                reqWrite   = memWe;
                reqData    = memWdata;
                rngState   = xorshift32(rngState);
                ackWait    = 1 + int'(rngState[1:0]);   // 1 to 4 cycles
                reqPending = 1'b1;
            end
            @(posedge clk);
            #1;
            rngState = xorshift32(rngState);
            memAck   = 1'b0;
            memRdata = rngState;                        // Noise between acks
            memBusy  = (rngState[9:8] == 2'b00);        // Busy about one cycle in four
            if (reqPending)
            begin
                ackWait = ackWait - 1;
                if (ackWait == 0)
                begin
                    if (reqWrite)
                        mem[reqAddr[9:2]] = reqData;
                    else
                        memRdata = mem[reqAddr[9:2]];
                    memAck     = 1'b1;
                    reqPending = 1'b0;
                end
            end
        end
    end

    initial
    begin
        reset = 1'b1;
        expStores = '{
            {32'h0000_0200, 32'h0000_0002},     // add
            {32'h0000_0204, 32'hffff_fff8},     // sub
            {32'h0000_0208, 32'h0000_0001},     // slt true
            {32'h0000_020c, 32'h0000_0000},     // slt false
            {32'h0000_0210, 32'h0000_0001},     // slti
            {32'h0000_0214, 32'hffff_fffd},     // or
            {32'h0000_0218, 32'h0000_00f5},     // and
            {32'h0000_021c, 32'h0000_0000},     // x0
            {32'h0000_0220, 32'h1234_5678},     // lw then sw
            {32'h0000_0118, 32'hcafe_f00d},
            {32'h0000_0224, 32'h0000_0005},     // beq not taken path
            {32'h0000_022c, 32'h0000_0002},     // beq taken path
            {32'h0000_0238, 32'h0000_0080}      // jal link
        };
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!haltSeen && cycles < TimeoutCycles)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!haltSeen)
        begin
            timedOut = 1'b1;
            $display("timeout: core did not halt within %0d cycles", TimeoutCycles);
        end
        else
            repeat (QuietCycles) @(posedge clk);    // No strobe may follow the halt
        $display("errors %0d, stores %0d of %0d, cycles %0d",
                 errorCount, storeCount, NumStores, cycles);
        if (errorCount == 0 && !timedOut)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: rvCore.f
+incdir+common
common/rvCorePkg.sv
rtl/controller.sv
datapath/rvAlu.sv
datapath/regFile.sv
datapath/rvDatapath.sv
rtl/rvCore.sv
tb/rvCoreChecker.sv
tb/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the rvCore testbench with Verilator and run it
# The run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module rvCoreTb \
    -f rvCore.f -o rvCoreSim \
    && ./obj_dir/rvCoreSim | tee sim.log \
    || echo "build or simulation did not complete"

grep -qx "ALL TESTS PASSED" sim.log && exit 0 || exit 1
